// ==== control_path.f ====
+incdir+source
source/control_path_pkg.sv
source/thread_pc.sv
source/instr_mem.sv
source/branch_fold.sv
source/control_path.sv
bench/control_path_assert.sv
bench/control_path_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := control_path_tb
FILELIST  := control_path.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation PASSED"; \
	else echo "simulation FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/control_path_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_path_defs.svh"

module control_path_tb;

    localparam int PC_W       = `CP_PC_WIDTH;
    localparam int WA_W       = `CP_WRITE_ADDR_WIDTH;
    localparam int W_W        = `CP_WORD_WIDTH;
    localparam int THREADS    = `CP_THREAD_COUNT;
    localparam int PER_THREAD = `CP_BRANCHES_PER_THREAD;
    localparam int ENTRIES    = `CP_THREAD_COUNT * `CP_BRANCHES_PER_THREAD;
    localparam int WAIT_LIMIT = 200;

    logic               clock;
    logic               rst_n;
    logic               write_en;
    logic [WA_W-1:0]    write_addr;
    logic [W_W-1:0]     write_data;
    logic [W_W-1:0]     result;
    logic               io_ready;
    logic [W_W-1:0]     instr;
    logic               cancel;

    // reference model of the PCs, the thread order and both memories
    logic [PC_W-1:0]                    model_pc [0:THREADS-1];
    int                                 model_thread;
    logic [W_W-1:0]                     model_imem [0:`CP_I_DEPTH-1];
    bit                                 model_known [0:`CP_I_DEPTH-1];
    control_path_pkg::branch_entry_t    model_table [0:ENTRIES-1];
    logic [W_W-1:0]                     expect_words [$];
    bit                                 expect_known [$];
    logic [31:0]                        rng_state;

    control_path dut0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .result     (result),
        .io_ready   (io_ready),
        .instr      (instr),
        .cancel     (cancel)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic bit cond_met(input control_path_pkg::branch_cond_e cond,
                                    input logic [W_W-1:0] value);
        case (cond)
            control_path_pkg::cond_zero:     return value == '0;
            control_path_pkg::cond_nonzero:  return value != '0;
            control_path_pkg::cond_negative: return value[W_W-1];
            default:                         return 1'b1;
        endcase
    endfunction

    function automatic logic [W_W-1:0] make_entry(input logic annul,
            input control_path_pkg::branch_cond_e cond,
            input logic [PC_W-1:0] origin, input logic [PC_W-1:0] dest);
        control_path_pkg::write_word_u w;
        w = '0;
        w.branch.enable      = 1'b1;
        w.branch.annul       = annul;
        w.branch.condition   = cond;
        w.branch.origin      = origin;
        w.branch.destination = dest;
        return w;
    endfunction

    function automatic logic [WA_W-1:0] entry_addr(input int t, input int e);
        return WA_W'(`CP_BRANCH_BASE + t * PER_THREAD + e);
    endfunction

    // a result word that makes the condition hold or fail on purpose
    function automatic logic [W_W-1:0] pick_result(input control_path_pkg::branch_cond_e cond,
                                                   input bit holds, input logic [W_W-1:0] r);
        case (cond)
            control_path_pkg::cond_zero:     return holds ? '0 : (r | 32'd1);
            control_path_pkg::cond_nonzero:  return holds ? (r | 32'd1) : '0;
            control_path_pkg::cond_negative: return holds ? (r | 32'h8000_0000) : (r & 32'h7fff_ffff);
            default:                         return r;
        endcase
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [W_W-1:0] got,
                               input logic [W_W-1:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    // ****************************************
    // one issue cycle, from falling edge to falling edge

    task automatic issue_cycle(input logic ready, input logic [W_W-1:0] res, input logic wr,
                               input logic [WA_W-1:0] addr, input logic [W_W-1:0] data);
        int t;
        int idx;
        int offset;
        logic [PC_W-1:0] p;
        bit jump_e;
        bit cancel_e;
        logic [PC_W-1:0] dest_e;
        io_ready   = ready;
        result     = res;
        write_en   = wr;
        write_addr = addr;
        write_data = data;
        #5;
        t = model_thread;
        p = model_pc[t];
        jump_e = 1'b0;
        cancel_e = 1'b0;
        dest_e = '0;
        // entry 0 is looked at first and keeps the branch once it matches
        for (int e = 0; e < PER_THREAD; e++) begin
            idx = t * PER_THREAD + e;
            if (!jump_e && model_table[idx].enable && model_table[idx].origin == p
                    && cond_met(model_table[idx].condition, res)) begin
                jump_e = 1'b1;
                dest_e = model_table[idx].destination;
                cancel_e = model_table[idx].annul;
            end
        end
        check_value("cancel", W_W'(cancel), W_W'(cancel_e));
        // instr shows the word fetched two cycles earlier
        if (expect_words.size() == 2) begin
            if (expect_known.pop_front()) begin
                check_value("instr", instr, expect_words.pop_front());
            end else begin
                void'(expect_words.pop_front());
            end
        end
        expect_words.push_back(model_imem[p]);
        expect_known.push_back(model_known[p]);
        if (ready || cancel_e) begin
            model_pc[t] = jump_e ? dest_e : PC_W'(p + 8'd1);
        end
        if (wr) begin
            offset = int'(addr) - `CP_I_BASE;
            if (offset >= 0 && offset < `CP_I_DEPTH) begin
                model_imem[offset] = data;
                model_known[offset] = 1'b1;
            end
            offset = int'(addr) - `CP_BRANCH_BASE;
            if (offset >= 0 && offset < ENTRIES) begin
                model_table[offset] = data;
            end
        end
        model_thread = (t + 1) % THREADS;
        @(negedge clock);
    endtask

    task automatic idle_cycle(input logic ready);
        issue_cycle(ready, next_random(), 1'b0, '0, '0);
    endtask

    task automatic write_word(input logic [WA_W-1:0] addr, input logic [W_W-1:0] data);
        issue_cycle(1'b1, next_random(), 1'b1, addr, data);
    endtask

    // stops just before the given thread issues the given PC
    task automatic wait_for_issue(input int t, input logic [PC_W-1:0] origin);
        int count;
        count = 0;
        while (model_thread != t || model_pc[t] != origin) begin
            if (count == WAIT_LIMIT) begin
                $display("Timeout: thread %0d never reached PC %h", t, origin);
                abort_run();
            end
            idle_cycle(1'b1);
            count++;
        end
    endtask

    // ****************************************
    // directed tests

    task automatic test_load_and_fetch();
        control_path_pkg::write_word_u w;
        logic [31:0] r;
        for (int a = 0; a < `CP_I_DEPTH; a++) begin
            r = next_random();
            w = '0;
            w.instr.opcode = r[3:0];
            w.instr.d      = r[13:4];
            w.instr.a      = r[22:14];
            w.instr.b      = r[31:23];
            write_word(WA_W'(`CP_I_BASE + a), w);
        end
        repeat (64) idle_cycle(1'b1);
    endtask

    task automatic test_back_pressure();
        for (int i = 0; i < 48; i++) begin
            idle_cycle((i % 5) != 2 && (i % 7) != 4);
        end
    endtask

    task automatic test_unconditional();
        logic [PC_W-1:0] origin;
        origin = PC_W'(model_pc[2] + 8'd3);
        write_word(entry_addr(2, 0), make_entry(1'b0, control_path_pkg::cond_always,
                                                origin, PC_W'(next_random())));
        wait_for_issue(2, origin);
        repeat (16) idle_cycle(1'b1);
    endtask

    task automatic test_conditional();
        control_path_pkg::branch_cond_e cond;
        logic [PC_W-1:0] origin;
        for (int k = 0; k < 6; k++) begin
            cond = control_path_pkg::branch_cond_e'(2'(k / 2 + 1));
            origin = PC_W'(model_pc[1] + 8'd2);
            write_word(entry_addr(1, 0), make_entry(1'b0, cond, origin, PC_W'(next_random())));
            wait_for_issue(1, origin);
            issue_cycle(1'b1, pick_result(cond, (k % 2) == 0, next_random()), 1'b0, '0, '0);
            repeat (12) idle_cycle(1'b1);
        end
    endtask

    task automatic test_annul();
        logic [PC_W-1:0] origin;
        for (int k = 0; k < 2; k++) begin
            origin = PC_W'(model_pc[3] + 8'd2);
            write_word(entry_addr(3, 0), make_entry(1'b1, control_path_pkg::cond_negative,
                                                    origin, PC_W'(next_random())));
            wait_for_issue(3, origin);
            // io_ready stays low, so only a taken branch lets the thread move
            issue_cycle(1'b0, pick_result(control_path_pkg::cond_negative, k == 0,
                                          next_random()), 1'b0, '0, '0);
            repeat (8) idle_cycle(1'b1);
        end
    endtask

    task automatic test_isolation_priority();
        logic [PC_W-1:0] origin;
        logic [PC_W-1:0] dest0;
        origin = PC_W'(model_pc[0] + 8'd2);
        write_word(WA_W'(`CP_BRANCH_BASE + ENTRIES), make_entry(1'b1,
                   control_path_pkg::cond_always, origin, 8'h00));
        write_word(WA_W'(`CP_I_BASE + `CP_I_DEPTH), next_random());
        write_word(WA_W'(`CP_BRANCH_BASE - 1), next_random());
        write_word(WA_W'(10'h3ff), next_random());
        repeat (24) idle_cycle(1'b1);
        origin = PC_W'(model_pc[0] + 8'd2);
        // thread 0 then fetches words 0xff and 0x00, which share low address bits
        // with the ignored writes above
        dest0 = 8'hff;
        write_word(entry_addr(0, 1), make_entry(1'b0, control_path_pkg::cond_always,
                                                origin, ~dest0));
        write_word(entry_addr(0, 0), make_entry(1'b1, control_path_pkg::cond_always,
                                                origin, dest0));
        wait_for_issue(0, origin);
        issue_cycle(1'b0, next_random(), 1'b0, '0, '0);
        repeat (16) idle_cycle(1'b1);
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        write_en = 1'b0;
        write_addr = '0;
        write_data = '0;
        result = '0;
        io_ready = 1'b1;
        rng_state = 32'ha958a102;
        model_thread = 0;
        for (int t = 0; t < THREADS; t++) begin
            model_pc[t] = PC_W'(t * `CP_THREAD_STRIDE);
        end
        for (int i = 0; i < `CP_I_DEPTH; i++) begin
            model_imem[i] = '0;
            model_known[i] = 1'b0;
        end
        for (int e = 0; e < ENTRIES; e++) begin
            model_table[e] = '0;
        end
        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        test_load_and_fetch();
        test_back_pressure();
        test_unconditional();
        test_conditional();
        test_annul();
        test_isolation_priority();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/control_path_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_path_defs.svh"

module control_path_assert (
    input wire                          clock,
    input wire                          rst_n,
    input wire                          jump,
    input wire  [`CP_PC_WIDTH-1:0]      destination,
    input wire                          cancel
);

    // an annulled instruction always belongs to a taken branch
    cancel_needs_jump: assert property (
        @(posedge clock) disable iff (!rst_n) cancel |-> jump
    ) else $error("cancel is high while jump is low");

    // reset clears every enable bit, so nothing may fire
    quiet_in_reset: assert property (
        @(posedge clock) !rst_n |-> (!jump && !cancel)
    ) else $error("jump or cancel is high during reset");

    known_destination: assert property (
        @(posedge clock) disable iff (!rst_n) jump |-> !$isunknown(destination)
    ) else $error("destination has unknown bits while jump is high");

endmodule

bind branch_fold control_path_assert bf_checks (
    .clock       (clock),
    .rst_n       (rst_n),
    .jump        (jump),
    .destination (destination),
    .cancel      (cancel)
);

`default_nettype wire

// ==== source/control_path.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_path_defs.svh"

module control_path (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire                                 write_en,
    input  wire  [`CP_WRITE_ADDR_WIDTH-1:0]     write_addr,
    input  wire  [`CP_WORD_WIDTH-1:0]           write_data,
    input  wire  [`CP_WORD_WIDTH-1:0]           result,
    input  wire                                 io_ready,
    output logic [`CP_WORD_WIDTH-1:0]           instr,
    output logic                                cancel
);

    control_path_pkg::write_word_u  write_word;
    control_path_pkg::write_word_u  instr_word;

    logic [`CP_PC_WIDTH-1:0]        pc;
    logic [`CP_THREAD_WIDTH-1:0]    thread;
    logic                           jump;
    logic [`CP_PC_WIDTH-1:0]        destination;
    logic                           issue_ready;

    assign write_word = write_data;
    assign instr      = instr_word;

    // a cancelled instruction counts as ready so it is never issued again
    assign issue_ready = io_ready | cancel;

    // ****************************************
    // producer, buffer and consumer

    thread_pc pc_gen (
        .clock       (clock),
        .rst_n       (rst_n),
        .jump        (jump),
        .destination (destination),
        .issue_ready (issue_ready),
        .pc          (pc),
        .thread      (thread)
    );

    instr_mem i_mem (
        .clock      (clock),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_word),
        .read_addr  (pc),
        .read_data  (instr_word)
    );

    branch_fold bf (
        .clock       (clock),
        .rst_n       (rst_n),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_data  (write_word),
        .pc          (pc),
        .thread      (thread),
        .result      (result),
        .jump        (jump),
        .destination (destination),
        .cancel      (cancel)
    );

endmodule

`default_nettype wire

// ==== source/branch_fold.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_path_defs.svh"

module branch_fold (
    input  wire                                 clock,
    input  wire                                 rst_n,
    input  wire                                 write_en,
    input  wire  [`CP_WRITE_ADDR_WIDTH-1:0]     write_addr,
    input  wire  control_path_pkg::write_word_u write_data,
    input  wire  [`CP_PC_WIDTH-1:0]             pc,
    input  wire  [`CP_THREAD_WIDTH-1:0]         thread,
    input  wire  [`CP_WORD_WIDTH-1:0]           result,
    output logic                                jump,
    output logic [`CP_PC_WIDTH-1:0]             destination,
    output logic                                cancel
);

    localparam int WA_W       = `CP_WRITE_ADDR_WIDTH;
    localparam int PC_W       = `CP_PC_WIDTH;
    localparam int PER_THREAD = `CP_BRANCHES_PER_THREAD;
    localparam int ENTRIES    = `CP_THREAD_COUNT * PER_THREAD;
    localparam int IDX_W      = $clog2(ENTRIES);

    logic [WA_W-1:0]    b_offset;
    logic               b_we;
    logic [IDX_W-1:0]   b_idx;

    logic                           enable_q [0:ENTRIES-1];
    logic                           annul_q  [0:ENTRIES-1];
    control_path_pkg::branch_cond_e cond_q   [0:ENTRIES-1];
    logic [PC_W-1:0]                origin_q [0:ENTRIES-1];
    logic [PC_W-1:0]                dest_q   [0:ENTRIES-1];

    function automatic logic cond_holds(
        input control_path_pkg::branch_cond_e cond,
        input logic [`CP_WORD_WIDTH-1:0]      value
    );
        logic holds;
        case (cond)
            control_path_pkg::cond_always:   holds = 1'b1;
            control_path_pkg::cond_zero:     holds = (value == '0);
            control_path_pkg::cond_nonzero:  holds = (value != '0);
            control_path_pkg::cond_negative: holds = value[`CP_WORD_WIDTH-1];
            default:                         holds = 1'b0;
        endcase
        return holds;
    endfunction

    // ****************************************
    // branch table writes

    // the entry index is thread times entries per thread plus entry number
    assign b_offset = write_addr - WA_W'(`CP_BRANCH_BASE);
    assign b_we     = write_en & (b_offset < WA_W'(ENTRIES));
    assign b_idx    = b_offset[IDX_W-1:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                enable_q[i] <= 1'b0;
            end
        end else if (b_we) begin
            enable_q[b_idx] <= write_data.branch.enable;
        end
    end

    always_ff @(posedge clock) begin
        if (b_we) begin
            annul_q[b_idx]  <= write_data.branch.annul;
            cond_q[b_idx]   <= write_data.branch.condition;
            origin_q[b_idx] <= write_data.branch.origin;
            dest_q[b_idx]   <= write_data.branch.destination;
        end
    end

    // ****************************************
    // origin match and priority

    // walking from the last entry down lets entry 0 override any other match
    always_comb begin
        logic [IDX_W-1:0] idx;
        jump        = 1'b0;
        destination = '0;
        cancel      = 1'b0;
        for (int e = PER_THREAD - 1; e >= 0; e--) begin
            idx = IDX_W'(int'(thread) * PER_THREAD + e);
            if (enable_q[idx] && (origin_q[idx] == pc) && cond_holds(cond_q[idx], result)) begin
                jump        = 1'b1;
                destination = dest_q[idx];
                cancel      = annul_q[idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/instr_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_path_defs.svh"

module instr_mem (
    input  wire                                 clock,
    input  wire                                 write_en,
    input  wire  [`CP_WRITE_ADDR_WIDTH-1:0]     write_addr,
    input  wire  control_path_pkg::write_word_u write_data,
    input  wire  [`CP_PC_WIDTH-1:0]             read_addr,
    output control_path_pkg::write_word_u       read_data
);

    localparam int WA_W = `CP_WRITE_ADDR_WIDTH;
    localparam int PC_W = `CP_PC_WIDTH;
    localparam int TAPS = `CP_TAP_DEPTH;

    logic [WA_W-1:0]    i_offset;
    logic               i_hit;
    logic               i_we;

    control_path_pkg::instr_t ram [0:`CP_I_DEPTH-1];
    control_path_pkg::instr_t ram_q;
    control_path_pkg::instr_t tap_q [0:TAPS-1];

    // ****************************************
    // instruction window decode

    assign i_offset = write_addr - WA_W'(`CP_I_BASE);
    assign i_hit    = (i_offset < WA_W'(`CP_I_DEPTH));
    assign i_we     = i_hit & write_en;

    // ****************************************
    // simple dual-port RAM

    // a read in the same cycle as a write to that word sees the old word
    always_ff @(posedge clock) begin
        if (i_we) begin
            ram[i_offset[PC_W-1:0]] <= write_data.instr;
        end
        ram_q <= ram[read_addr];
    end

    // ****************************************
    // output tap stages

    // plain registers with nothing in between, so they can move into the RAM
    always_ff @(posedge clock) begin
        tap_q[0] <= ram_q;
        for (int s = 1; s < TAPS; s++) begin
            tap_q[s] <= tap_q[s-1];
        end
    end

    always_comb begin
        read_data.instr = tap_q[TAPS-1];
    end

endmodule

`default_nettype wire

// ==== source/thread_pc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_path_defs.svh"

module thread_pc (
    input  wire                             clock,
    input  wire                             rst_n,
    input  wire                             jump,
    input  wire  [`CP_PC_WIDTH-1:0]         destination,
    input  wire                             issue_ready,
    output logic [`CP_PC_WIDTH-1:0]         pc,
    output logic [`CP_THREAD_WIDTH-1:0]     thread
);

    localparam int PC_W    = `CP_PC_WIDTH;
    localparam int THR_W   = `CP_THREAD_WIDTH;
    localparam int THREADS = `CP_THREAD_COUNT;

    logic [PC_W-1:0]    pc_store [0:THREADS-1];
    logic [PC_W-1:0]    next_pc;
    logic [THR_W-1:0]   next_thread;

    // ****************************************
    // round-robin thread counter

    always_comb begin
        if (thread == THR_W'(THREADS - 1)) begin
            next_thread = '0;
        end else begin
            next_thread = thread + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            thread <= '0;
        end else begin
            thread <= next_thread;
        end
    end

    // ****************************************
    // per-thread PC store

    // the issuing thread's PC is read straight from its entry
    assign pc = pc_store[thread];

    // a stalled instruction is issued again on the thread's next turn,
    // otherwise a folded branch takes precedence over the sequential step
    always_comb begin
        if (!issue_ready) begin
            next_pc = pc;
        end else if (jump) begin
            next_pc = destination;
        end else begin
            next_pc = pc + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREADS; t++) begin
                pc_store[t] <= PC_W'(t * `CP_THREAD_STRIDE);
            end
        end else begin
            pc_store[thread] <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/control_path_pkg.sv ====
`default_nettype none

`include "control_path_defs.svh"

package control_path_pkg;

    // conditions are tested on the thread's previous result word
    typedef enum logic [1:0] {
        cond_always   = 2'd0,
        cond_zero     = 2'd1,
        cond_nonzero  = 2'd2,
        cond_negative = 2'd3
    } branch_cond_e;

    typedef struct packed {
        logic [3:0]                         opcode;
        logic [`CP_WRITE_ADDR_WIDTH-1:0]    d;
        logic [8:0]                         a;
        logic [8:0]                         b;
    } instr_t;

    typedef struct packed {
        logic                       enable;
        logic                       annul;
        branch_cond_e               condition;
        logic [`CP_PC_WIDTH-1:0]    origin;
        logic [`CP_PC_WIDTH-1:0]    destination;
        logic [11:0]                unused;
    } branch_entry_t;

    // one write data word, read as an instruction or as a branch entry
    typedef union packed {
        instr_t         instr;
        branch_entry_t  branch;
    } write_word_u;

endpackage

`default_nettype wire

// ==== source/control_path_defs.svh ====
`ifndef CONTROL_PATH_DEFS_SVH
`define CONTROL_PATH_DEFS_SVH

// ****************************************
// threads and word sizes

`define CP_THREAD_COUNT         4
`define CP_THREAD_WIDTH         2
`define CP_WORD_WIDTH           32
`define CP_WRITE_ADDR_WIDTH     10
`define CP_PC_WIDTH             8

// ****************************************
// write address map

// the instruction window covers one write address per instruction word
`define CP_I_DEPTH              256
`define CP_I_BASE               'h000
`define CP_BRANCH_BASE          'h200
`define CP_BRANCHES_PER_THREAD  2

// ****************************************
// fetch timing and thread start PCs

// thread t begins at t times the stride
`define CP_THREAD_STRIDE        64
`define CP_TAP_DEPTH            1

`endif
